//--- cpu8.f
+incdir+test
hw/cpu8_pkg.sv
hw/instr_decode.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/pc_unit.sv
hw/cpu8_top.sv
test/tb_cpu8.sv

//--- test/tb_cpu8_tests.svh
// pc from reset, then unknown opcodes only advance the pc
task automatic test_reset_nop();
    check_pc(pc, '0);
    repeat (4)
        run_instr(instr_u'(32'hFF00_0000));
    run_instr(instr_u'(32'h0812_3456));     // 0x08 is unused too
    run_instr(instr_u'(32'hFE07_0707));
endtask

task automatic test_load_mov();
    data_t v;
    run_instr(make_alu(OP_MOV, 3, 0, 8'h05));   // r5 still holds its reset value
    run_instr(make_alu(OP_MOV, 4, 0, 8'h07));
    v = lcg_byte();
    run_instr(make_alu(OP_LOADI, 2, 0, v));
    run_instr(make_alu(OP_MOV, 6, 0, 8'h02));   // copy of r2
    run_instr(make_alu(OP_LOADI, 7, 0, 8'hA5));
    run_instr(make_alu(OP_MOV, 0, 0, 8'h07));
endtask

// random operands into r1 and r2, all four ops each round
task automatic test_alu_ops();
    for (int i = 0; i < 16; i++)
    begin
        run_instr(make_alu(OP_LOADI, 1, 0, lcg_byte()));
        run_instr(make_alu(OP_LOADI, 2, 0, lcg_byte()));
        run_instr(make_alu(OP_ADD, 3, 1, 8'h02));
        run_instr(make_alu(OP_SUB, 4, 1, 8'h02));
        run_instr(make_alu(OP_AND, 5, 1, 8'h02));
        run_instr(make_alu(OP_OR, 6, 1, 8'h02));
    end
    run_instr(make_alu(OP_SUB, 7, 1, 8'h01));   // same register, result 0
    run_instr(make_alu(OP_ADD, 7, 3, 8'h04));
endtask

task automatic test_branches();
    data_t x;
    x = lcg_byte();
    run_instr(make_alu(OP_LOADI, 1, 0, x));
    run_instr(make_alu(OP_LOADI, 2, 0, x));
    run_instr(make_br(OP_BEQ, 8'h02, 1, 2));    // equal, taken
    run_instr(make_br(OP_BNE, 8'h03, 1, 2));    // equal, falls through
    run_instr(make_alu(OP_LOADI, 2, 0, x + 8'd1));
    run_instr(make_br(OP_BEQ, 8'h04, 1, 2));    // unequal, falls through
    run_instr(make_br(OP_BNE, 8'hFE, 1, 2));    // unequal, taken backwards
    run_instr(make_br(OP_BNE, 8'h00, 2, 1));    // taken, offset 0
    run_instr(make_alu(OP_OR, 3, 1, 8'h02));
endtask

// forward and backward jumps, then straight code from the new pc
task automatic test_jumps();
    run_instr(make_br(OP_JUMP, 8'h05, 0, 0));
    run_instr(make_alu(OP_LOADI, 4, 0, lcg_byte()));
    run_instr(make_br(OP_JUMP, 8'hF9, 0, 0));   // back 7 words
    run_instr(make_alu(OP_MOV, 5, 0, 8'h04));
    run_instr(make_br(OP_JUMP, 8'h00, 0, 0));   // lands on pc+4
    run_instr(make_br(OP_JUMP, 8'h80, 0, 0));   // most negative offset
    run_instr(make_alu(OP_ADD, 6, 4, 8'h05));
    run_instr(make_alu(OP_SUB, 7, 6, 8'h04));
    check_pc(pc, exp_pc);
endtask

//--- test/tb_cpu8.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu8
    import cpu8_pkg::*;
;

    localparam int HALF_PERIOD = 50;           // 100 ns clock
    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES = 200;          // rough length of all tests
    localparam int MAX_CYCLES = 2 * TEST_CYCLES;

    logic       CLK = 1'b0;
    logic       rst_n;
    instr_u     instr;
    pc_t        pc;
    reg_write_t reg_write;

    data_t       model_regs [REG_N];           // expected register contents
    pc_t         exp_pc;                       // expected fetch address
    logic [31:0] lcg_state = 32'h3bbe;
    int          err_mismatch = 0;
    int          err_other = 0;
    int          cycle_cnt = 0;

    cpu8_top dut0 (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .instr     (instr),
        .pc        (pc),
        .reg_write (reg_write)
    );

    always #HALF_PERIOD CLK = ~CLK;

    // run limit, well past the tests
    always @(posedge CLK)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d mismatch, %0d other", err_mismatch, err_other);
            $display("TEST FAILED");
            $finish;
        end
    end

    // operand source, bits 23:16 of the state
    function automatic data_t lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic instr_u make_alu(input logic [7:0] op, input int rd, input int rs1,
                                        input logic [7:0] src2_imm);
        instr_u w;
        w.alu = '{opcode: op, dest: 8'(rd), src1: 8'(rs1), src2_imm: src2_imm};
        return w;
    endfunction

    function automatic instr_u make_br(input logic [7:0] op, input logic [7:0] offset,
                                       input int rs1, input int rs2);
        instr_u w;
        w.br = '{opcode: op, offset: offset, src1: 8'(rs1), src2: 8'(rs2)};
        return w;
    endfunction

    // what the write port should carry for word w, from the model registers
    function automatic reg_write_t expect_write(input instr_u w);
        reg_write_t e;
        data_t      a;
        data_t      b;
        e = '0;
        a = model_regs[w.alu.src1[REG_AW-1:0]];
        b = model_regs[w.alu.src2_imm[REG_AW-1:0]];
        e.addr = w.alu.dest[REG_AW-1:0];
        e.en = 1'b1;
        case (w.alu.opcode)
            OP_LOADI: e.data = w.alu.src2_imm;
            OP_MOV:   e.data = b;
            OP_ADD:   e.data = a + b;
            OP_SUB:   e.data = a + (~b + 8'd1);     // two's complement of src2
            OP_AND:   e.data = a & b;
            OP_OR:    e.data = a | b;
            default:  e.en = 1'b0;                  // jump, branches, no-ops
        endcase
        return e;
    endfunction

    function automatic pc_t expect_pc(input instr_u w);
        data_t a;
        data_t b;
        int    off_words;
        logic  taken;
        a = model_regs[w.br.src1[REG_AW-1:0]];
        b = model_regs[w.br.src2[REG_AW-1:0]];
        off_words = $signed(w.br.offset);
        taken = (w.br.opcode == OP_JUMP) || (w.br.opcode == OP_BEQ && a == b)
                || (w.br.opcode == OP_BNE && a != b);
        if (taken)
            return exp_pc + pc_t'(PC_STEP) + pc_t'(off_words * 4);
        else
            return exp_pc + pc_t'(PC_STEP);
    endfunction

    task automatic check_pc(input pc_t got, input pc_t exp);
        if ($isunknown(got))
        begin
            $display("pc has unknown bits at cycle %0d", cycle_cnt);
            err_other++;
        end
        else if (got !== exp)
        begin
            $display("mismatch pc: got %h expected %h", got, exp);
            err_mismatch++;
        end
    endtask

    task automatic check_write(input reg_write_t got, input reg_write_t exp);
        if (got.en !== exp.en)
        begin
            $display("mismatch reg_write.en: got %h expected %h", got.en, exp.en);
            err_mismatch++;
        end
        else if (exp.en && (got.addr !== exp.addr || got.data !== exp.data))
        begin
            $display("mismatch reg_write: got %h/%h expected %h/%h (addr/data)",
                     got.addr, got.data, exp.addr, exp.data);
            err_mismatch++;
        end
    endtask

    // called at a falling edge, returns at the next one
    task automatic run_instr(input instr_u w);
        reg_write_t exp_wr;
        pc_t        next_pc;
        check_pc(pc, exp_pc);                    // fetch address for this word
        instr = w;
        #(HALF_PERIOD / 2);                      // write port settled
        exp_wr = expect_write(w);
        next_pc = expect_pc(w);
        check_write(reg_write, exp_wr);
        if (exp_wr.en)
            model_regs[exp_wr.addr] = exp_wr.data;
        exp_pc = next_pc;
        @(negedge CLK);
    endtask

    `include "tb_cpu8_tests.svh"

    initial
    begin
        rst_n = 1'b0;
        instr = instr_u'(32'hFF00_0000);         // unknown opcode during reset
        exp_pc = '0;
        for (int i = 0; i < REG_N; i++)
            model_regs[i] = '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        test_reset_nop();
        test_load_mov();
        test_alu_ops();
        test_branches();
        test_jumps();
        $display("errors: %0d mismatch, %0d other", err_mismatch, err_other);
        if (err_mismatch == 0 && err_other == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/cpu8_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu8_top
    import cpu8_pkg::*;
(
    input  logic       CLK,
    input  logic       rst_n,
    input  instr_u     instr,      // word for the current pc
    output pc_t        pc,         // fetch address
    output reg_write_t reg_write   // write port trace, valid before the edge
);

    ctrl_t     ctrl;      // decoded control
    reg_addr_t rd_addr1;  // src1 index
    reg_addr_t rd_addr2;  // src2 index
    reg_addr_t wr_addr;   // dest index
    data_t     imm;       // low byte of the word
    data_t     rd_data1;
    data_t     rd_data2;
    data_t     result;    // alu output
    logic      zero;      // result was all zeros

    instr_decode u_decode (
        .instr    (instr),
        .ctrl     (ctrl),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .imm      (imm),
        .wr_addr  (wr_addr)
    );

    reg_file u_regs (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wr       (reg_write)   // same struct drives the file and the trace
    );

    execute_unit u_exec (
        .ctrl     (ctrl),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .imm      (imm),
        .result   (result),
        .zero     (zero)
    );

    pc_unit u_pc (
        .CLK    (CLK),
        .rst_n  (rst_n),
        .ctrl   (ctrl),
        .zero   (zero),
        .offset (instr.br.offset),  // control flow view of bits 23:16
        .pc     (pc)
    );

    assign reg_write = '{en: ctrl.reg_we, addr: wr_addr, data: result};  // decode + exec

endmodule

`default_nettype wire

//--- hw/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit
    import cpu8_pkg::*;
(
    input  logic  CLK,
    input  logic  rst_n,
    input  ctrl_t ctrl,    // branch, branch_ne and jump used here
    input  logic  zero,    // from execute
    input  data_t offset,  // signed word count
    output pc_t   pc       // current fetch address
);

    localparam int EXT_W = PC_W - DATA_W - 2;  // sign bits above the shifted offset

    pc_t  pc_plus4;    // sequential address
    pc_t  offset_ext;  // offset in bytes, sign extended
    pc_t  target;      // shared by jump and branch
    logic take;        // redirect this cycle

    assign pc_plus4 = pc + PC_W'(PC_STEP);

    // words to bytes, times 4
    assign offset_ext = {{EXT_W{offset[DATA_W-1]}}, offset, 2'b00};

    // relative to the next sequential word
    assign target = pc_plus4 + offset_ext;

    // beq takes on zero, bne on nonzero
    assign take = ctrl.jump | (ctrl.branch & (zero ^ ctrl.branch_ne));

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            pc <= '0;  // fetch restarts at 0
        end
        else if (take)
        begin
            pc <= target;
        end
        else
        begin
            pc <= pc_plus4;  // also for no-ops
        end
    end

    // fetch must stay word aligned across every redirect
    a_pc_aligned: assert property (
        @(posedge CLK) disable iff (!rst_n)
        pc[1:0] == 2'b00
    )
        else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit
    import cpu8_pkg::*;
(
    input  ctrl_t ctrl,      // use_imm, negate and alu_op used here
    input  data_t rd_data1,  // operand a
    input  data_t rd_data2,  // operand b from the file
    input  data_t imm,       // operand b from the word
    output data_t result,    // write data for rd
    output logic  zero       // result all zeros, drives branches
);

    data_t opnd_b;    // after the immediate select
    data_t opnd_neg;  // after optional negation

    // operand b source
    assign opnd_b = ctrl.use_imm ? imm : rd_data2;

    // two's complement for sub, beq and bne
    assign opnd_neg = ctrl.negate ? (~opnd_b + data_t'(1)) : opnd_b;

    always_comb
    begin
        case (ctrl.alu_op)
            ALU_FWD:
            begin
                result = opnd_neg;             // loadi, mov
            end
            ALU_ADD:
            begin
                result = rd_data1 + opnd_neg;  // carry out dropped
            end
            ALU_AND:
            begin
                result = rd_data1 & opnd_neg;
            end
            ALU_OR:
            begin
                result = rd_data1 | opnd_neg;
            end
            default:
            begin
                result = opnd_neg;
            end
        endcase
    end

    // equal operands give a zero difference
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import cpu8_pkg::*;
(
    input  logic       CLK,
    input  logic       rst_n,
    input  reg_addr_t  rd_addr1,  // port 1 index
    input  reg_addr_t  rd_addr2,  // port 2 index
    output data_t      rd_data1,
    output data_t      rd_data2,
    input  reg_write_t wr         // en, addr, data
);

    data_t regs [REG_N];  // the eight registers

    // write on the edge, all registers clear in reset
    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < REG_N; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr.en)
        begin
            regs[wr.addr] <= wr.data;  // visible to reads next cycle
        end
    end

    // reads have no clock, old value until the write edge
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

    // an X index from decode would corrupt an unknown register
    a_wr_addr_known: assert property (
        @(posedge CLK) disable iff (!rst_n)
        wr.en |-> !$isunknown(wr.addr)
    )
        else $error("register write with unknown address");

endmodule

`default_nettype wire

//--- hw/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode
    import cpu8_pkg::*;
(
    input  instr_u    instr,     // word for the current pc
    output ctrl_t     ctrl,      // control for execute and pc
    output reg_addr_t rd_addr1,  // src1 index
    output reg_addr_t rd_addr2,  // src2 index
    output data_t     imm,       // immediate byte
    output reg_addr_t wr_addr    // dest index
);

    always_comb
    begin
        ctrl = CTRL_NOP;  // anything unlisted retires as a no-op
        case (instr.alu.opcode)
            OP_LOADI:
            begin
                ctrl.reg_we  = 1'b1;
                ctrl.use_imm = 1'b1;     // immediate goes straight to rd
                ctrl.alu_op  = ALU_FWD;
            end
            OP_MOV:
            begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = ALU_FWD;   // forward rs2
            end
            OP_ADD:
            begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = ALU_ADD;
            end
            OP_SUB:
            begin
                ctrl.reg_we = 1'b1;
                ctrl.negate = 1'b1;      // rs1 + (-rs2)
                ctrl.alu_op = ALU_ADD;
            end
            OP_AND:
            begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = ALU_AND;
            end
            OP_OR:
            begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = ALU_OR;
            end
            OP_JUMP:
            begin
                ctrl.jump = 1'b1;        // no register write
            end
            OP_BEQ:
            begin
                ctrl.branch = 1'b1;
                ctrl.negate = 1'b1;      // zero flag set when rs1 == rs2
                ctrl.alu_op = ALU_ADD;
            end
            OP_BNE:
            begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = 1'b1;   // take on a nonzero difference
                ctrl.negate    = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end
            default:
            begin
                ctrl = CTRL_NOP;
            end
        endcase
    end

    // register fields share positions in both views, alu view used here
    assign rd_addr1 = instr.alu.src1[REG_AW-1:0];
    assign rd_addr2 = instr.alu.src2_imm[REG_AW-1:0];
    assign wr_addr  = instr.alu.dest[REG_AW-1:0];
    assign imm      = instr.alu.src2_imm;  // full byte for loadi

endmodule

`default_nettype wire

//--- hw/cpu8_pkg.sv
`default_nettype none

package cpu8_pkg;

    localparam int DATA_W  = 8;   // register and alu width
    localparam int REG_N   = 8;   // registers in the file
    localparam int REG_AW  = 3;   // register index bits
    localparam int PC_W    = 32;  // byte address
    localparam int PC_STEP = 4;   // one instruction word per step

    // opcode byte, word bits 31:24
    localparam logic [7:0] OP_LOADI = 8'h00;  // rd = imm
    localparam logic [7:0] OP_MOV   = 8'h01;  // rd = rs2
    localparam logic [7:0] OP_ADD   = 8'h02;  // rd = rs1 + rs2
    localparam logic [7:0] OP_SUB   = 8'h03;  // rd = rs1 - rs2
    localparam logic [7:0] OP_AND   = 8'h04;  // rd = rs1 & rs2
    localparam logic [7:0] OP_OR    = 8'h05;  // rd = rs1 | rs2
    localparam logic [7:0] OP_JUMP  = 8'h06;  // unconditional, pc relative
    localparam logic [7:0] OP_BEQ   = 8'h07;  // taken when rs1 == rs2
    localparam logic [7:0] OP_BNE   = 8'h0D;  // taken when rs1 != rs2

    typedef logic [DATA_W-1:0] data_t;      // register value
    typedef logic [REG_AW-1:0] reg_addr_t;  // register index
    typedef logic [PC_W-1:0]   pc_t;        // byte address

    typedef enum logic [1:0] {
        ALU_FWD = 2'b00,  // pass operand b through
        ALU_ADD = 2'b01,  // also sub and compare, with negate
        ALU_AND = 2'b10,
        ALU_OR  = 2'b11
    } alu_op_t;

    // register form of the instruction word
    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] dest;      // low REG_AW bits pick the target
        logic [7:0] src1;      // low REG_AW bits used
        logic [7:0] src2_imm;  // register index or immediate
    } alu_instr_t;

    // control flow form, same word
    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] offset;    // signed word count from pc+4
        logic [7:0] src1;
        logic [7:0] src2;
    } br_instr_t;

    // bits 23:16 are dest for alu ops and offset for jump / branch
    typedef union packed {
        alu_instr_t alu;
        br_instr_t  br;
    } instr_u;

    typedef struct packed {
        logic    reg_we;     // write rd at the edge
        logic    use_imm;    // operand b from the immediate
        logic    negate;     // two's complement of operand b
        alu_op_t alu_op;
        logic    branch;     // conditional, compares via zero
        logic    branch_ne;  // invert the branch condition
        logic    jump;       // unconditional pc relative
    } ctrl_t;

    localparam ctrl_t CTRL_NOP = '0;  // decoded for unknown opcodes

    // register file write port, also the trace output
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        data_t     data;
    } reg_write_t;

endpackage

`default_nettype wire
